// ==== source/vis_pkg.sv ====
package vis_pkg;

  // Array size
  localparam int ANTENNAS = 4;

  // Baseline slots per sample, also the minimum strobe spacing
  localparam int TRATE = 10;
  localparam int SLOT_BITS = 4;

  // Antenna index width
  localparam int ANT_BITS = 2;

  // Samples per block of partial sums
  localparam int COUNT = 15;
  localparam int CNT_BITS = 4;

  // Blocks per output frame
  localparam int BLOCKS = 3;
  localparam int BLK_BITS = 2;

  // Partial sum holds +/-2 per sample over a block, so +/-30
  localparam int PBITS = 7;

  // Visibility accumulator width
  localparam int ACCUM = 32;

  // First antenna of each baseline slot
  // Slots 0..3 are the autos, 4..9 the cross pairs
  localparam logic [ANT_BITS-1:0] A_TAPS [TRATE] = '{
    2'd0,
    2'd1,
    2'd2,
    2'd3,
    2'd0,
    2'd0,
    2'd0,
    2'd1,
    2'd1,
    2'd2
  };

  // Second antenna of each baseline slot
  localparam logic [ANT_BITS-1:0] B_TAPS [TRATE] = '{
    2'd0,
    2'd1,
    2'd2,
    2'd3,
    2'd1,
    2'd2,
    2'd3,
    2'd2,
    2'd3,
    2'd3
  };

endpackage

// ==== source/sample_sequencer.sv ====
`timescale 1ns/1ps
module sample_sequencer (
  input  logic                          vis_clock,
  input  logic                          vis_reset,
  input  logic                          sig_valid_i,
  input  logic [vis_pkg::ANTENNAS-1:0]  sig_idata_i,
  input  logic [vis_pkg::ANTENNAS-1:0]  sig_qdata_i,
  output logic                          seq_valid_o,
  output logic [vis_pkg::SLOT_BITS-1:0] seq_slot_o,
  output logic                          seq_last_o,
  output logic                          a_i_o,
  output logic                          a_q_o,
  output logic                          b_i_o,
  output logic                          b_q_o
);
  import vis_pkg::*;

  // Sample held for slots 1..9
  logic [ANTENNAS-1:0]  samp_i;
  logic [ANTENNAS-1:0]  samp_q;
  logic                 blk_last;

  // Slot and sample counters
  logic                 busy;
  logic [SLOT_BITS-1:0] slot_cnt;
  logic [CNT_BITS-1:0]  samp_cnt;

  // Slot issued this cycle
  logic                 issue;
  logic [SLOT_BITS-1:0] issue_slot;
  logic [ANTENNAS-1:0]  cur_i;
  logic [ANTENNAS-1:0]  cur_q;
  logic                 cur_last;
  logic [ANT_BITS-1:0]  tap_a;
  logic [ANT_BITS-1:0]  tap_b;

  // Slot 0 goes out on the strobe cycle, straight from the inputs
  always_comb begin
    issue      = sig_valid_i | busy;
    issue_slot = sig_valid_i ? '0 : slot_cnt;
    cur_i      = sig_valid_i ? sig_idata_i : samp_i;
    cur_q      = sig_valid_i ? sig_qdata_i : samp_q;
    cur_last   = sig_valid_i ? (samp_cnt == CNT_BITS'(COUNT - 1)) : blk_last;
    tap_a      = A_TAPS[issue_slot];
    tap_b      = B_TAPS[issue_slot];
  end

  always_ff @(posedge vis_clock) begin
    if (sig_valid_i) begin
      samp_i <= sig_idata_i;
      samp_q <= sig_qdata_i;
    end
  end

  always_ff @(posedge vis_clock) begin
    if (vis_reset) begin
      busy     <= 1'b0;
      slot_cnt <= '0;
      samp_cnt <= '0;
      blk_last <= 1'b0;
    end else if (sig_valid_i) begin
      busy     <= 1'b1;
      slot_cnt <= SLOT_BITS'(1);
      blk_last <= cur_last;
      samp_cnt <= cur_last ? '0 : samp_cnt + CNT_BITS'(1);
    end else if (busy) begin
      // Park at zero after the last slot
      if (slot_cnt == SLOT_BITS'(TRATE - 1)) begin
        busy     <= 1'b0;
        slot_cnt <= '0;
      end else begin
        slot_cnt <= slot_cnt + SLOT_BITS'(1);
      end
    end
  end

  always_ff @(posedge vis_clock) begin
    if (vis_reset) begin
      seq_valid_o <= 1'b0;
      seq_slot_o  <= '0;
      seq_last_o  <= 1'b0;
    end else begin
      seq_valid_o <= issue;
      seq_slot_o  <= issue_slot;
      seq_last_o  <= issue & cur_last;
    end
  end

  // Selected antenna bit-pairs
  always_ff @(posedge vis_clock) begin
    a_i_o <= cur_i[tap_a];
    a_q_o <= cur_q[tap_a];
    b_i_o <= cur_i[tap_b];
    b_q_o <= cur_q[tap_b];
  end

endmodule

// ==== source/baseline_correlator.sv ====
`timescale 1ns/1ps
module baseline_correlator (
  input  logic                                vis_clock,
  input  logic                                vis_reset,
  input  logic                                seq_valid_i,
  input  logic [vis_pkg::SLOT_BITS-1:0]       seq_slot_i,
  input  logic                                seq_last_i,
  input  logic                                a_i_i,
  input  logic                                a_q_i,
  input  logic                                b_i_i,
  input  logic                                b_q_i,
  output logic                                psum_valid_o,
  output logic [vis_pkg::SLOT_BITS-1:0]       psum_slot_o,
  output logic signed [vis_pkg::PBITS-1:0]    psum_re_o,
  output logic signed [vis_pkg::PBITS-1:0]    psum_im_o
);
  import vis_pkg::*;

  // Per-slot partial sums for the current block
  logic signed [PBITS-1:0] bank_re [TRATE];
  logic signed [PBITS-1:0] bank_im [TRATE];

  logic signed [PBITS-1:0] prod_re;
  logic signed [PBITS-1:0] prod_im;
  logic signed [PBITS-1:0] sum_re;
  logic signed [PBITS-1:0] sum_im;

  // Bit 1 means +1, bit 0 means -1
  // so a one-bit product is +1 when the bits agree
  function automatic logic signed [PBITS-1:0] pm1(input logic agree);
    logic signed [PBITS-1:0] one;
    one = PBITS'(1);
    return agree ? one : -one;
  endfunction

  // re = ai*bi + aq*bq, im = aq*bi - ai*bq
  always_comb begin
    prod_re = pm1(a_i_i ~^ b_i_i) + pm1(a_q_i ~^ b_q_i);
    prod_im = pm1(a_q_i ~^ b_i_i) - pm1(a_i_i ~^ b_q_i);
    sum_re  = bank_re[seq_slot_i] + prod_re;
    sum_im  = bank_im[seq_slot_i] + prod_im;
  end

  always_ff @(posedge vis_clock) begin
    if (vis_reset) begin
      for (int s = 0; s < TRATE; s++) begin
        bank_re[s] <= '0;
        bank_im[s] <= '0;
      end
      psum_valid_o <= 1'b0;
      psum_slot_o  <= '0;
      psum_re_o    <= '0;
      psum_im_o    <= '0;
    end else begin
      psum_valid_o <= seq_valid_i & seq_last_i;
      if (seq_valid_i) begin
        if (seq_last_i) begin
          // Block complete, hand on the sum and restart the slot
          psum_slot_o         <= seq_slot_i;
          psum_re_o           <= sum_re;
          psum_im_o           <= sum_im;
          bank_re[seq_slot_i] <= '0;
          bank_im[seq_slot_i] <= '0;
        end else begin
          bank_re[seq_slot_i] <= sum_re;
          bank_im[seq_slot_i] <= sum_im;
        end
      end
    end
  end

endmodule

// ==== source/vis_accumulator.sv ====
`timescale 1ns/1ps
module vis_accumulator (
  input  logic                             vis_clock,
  input  logic                             vis_reset,
  input  logic                             psum_valid_i,
  input  logic [vis_pkg::SLOT_BITS-1:0]    psum_slot_i,
  input  logic signed [vis_pkg::PBITS-1:0] psum_re_i,
  input  logic signed [vis_pkg::PBITS-1:0] psum_im_i,
  output logic                             vis_valid_o,
  output logic                             vis_last_o,
  output logic signed [vis_pkg::ACCUM-1:0] vis_revis_o,
  output logic signed [vis_pkg::ACCUM-1:0] vis_imvis_o
);
  import vis_pkg::*;

  // Frame totals per slot
  logic signed [ACCUM-1:0] acc_re [TRATE];
  logic signed [ACCUM-1:0] acc_im [TRATE];

  logic [BLK_BITS-1:0]     blk_cnt;
  logic                    final_blk;
  logic                    last_slot;
  logic signed [ACCUM-1:0] ext_re;
  logic signed [ACCUM-1:0] ext_im;
  logic signed [ACCUM-1:0] total_re;
  logic signed [ACCUM-1:0] total_im;

  always_comb begin
    final_blk = (blk_cnt == BLK_BITS'(BLOCKS - 1));
    last_slot = (psum_slot_i == SLOT_BITS'(TRATE - 1));
    ext_re    = {{(ACCUM - PBITS){psum_re_i[PBITS-1]}}, psum_re_i};
    ext_im    = {{(ACCUM - PBITS){psum_im_i[PBITS-1]}}, psum_im_i};
    total_re  = acc_re[psum_slot_i] + ext_re;
    total_im  = acc_im[psum_slot_i] + ext_im;
  end

  always_ff @(posedge vis_clock) begin
    if (vis_reset) begin
      for (int s = 0; s < TRATE; s++) begin
        acc_re[s] <= '0;
        acc_im[s] <= '0;
      end
      blk_cnt     <= '0;
      vis_valid_o <= 1'b0;
      vis_last_o  <= 1'b0;
      vis_revis_o <= '0;
      vis_imvis_o <= '0;
    end else begin
      vis_valid_o <= psum_valid_i & final_blk;
      vis_last_o  <= psum_valid_i & final_blk & last_slot;
      if (psum_valid_i) begin
        // Block ends with slot 9
        if (last_slot) begin
          blk_cnt <= final_blk ? '0 : blk_cnt + BLK_BITS'(1);
        end
        if (final_blk) begin
          vis_revis_o         <= total_re;
          vis_imvis_o         <= total_im;
          acc_re[psum_slot_i] <= '0;
          acc_im[psum_slot_i] <= '0;
        end else begin
          acc_re[psum_slot_i] <= total_re;
          acc_im[psum_slot_i] <= total_im;
        end
      end
    end
  end

endmodule

// ==== source/toy_correlator.sv ====
`timescale 1ns/1ps
module toy_correlator (
  input  logic                             vis_clock,
  input  logic                             vis_reset,
  input  logic                             sig_valid_i,
  input  logic [vis_pkg::ANTENNAS-1:0]     sig_idata_i,
  input  logic [vis_pkg::ANTENNAS-1:0]     sig_qdata_i,
  output logic signed [vis_pkg::ACCUM-1:0] vis_revis_o,
  output logic signed [vis_pkg::ACCUM-1:0] vis_imvis_o,
  output logic                             vis_valid_o,
  output logic                             vis_last_o,
  output logic                             vis_start_o,
  output logic                             vis_frame_o
);
  import vis_pkg::*;

  // Sequencer to correlator
  logic                 seq_valid;
  logic [SLOT_BITS-1:0] seq_slot;
  logic                 seq_last;
  logic                 a_i;
  logic                 a_q;
  logic                 b_i;
  logic                 b_q;

  // Correlator to accumulator
  logic                    psum_valid;
  logic [SLOT_BITS-1:0]    psum_slot;
  logic signed [PBITS-1:0] psum_re;
  logic signed [PBITS-1:0] psum_im;

  // Start pulse and frame level from the first strobe after reset
  always_ff @(posedge vis_clock) begin
    if (vis_reset) begin
      vis_start_o <= 1'b0;
      vis_frame_o <= 1'b0;
    end else begin
      vis_start_o <= sig_valid_i & ~vis_frame_o;
      if (sig_valid_i) begin
        vis_frame_o <= 1'b1;
      end
    end
  end

  sample_sequencer u_seq (
    .vis_clock   (vis_clock),
    .vis_reset   (vis_reset),
    .sig_valid_i (sig_valid_i),
    .sig_idata_i (sig_idata_i),
    .sig_qdata_i (sig_qdata_i),
    .seq_valid_o (seq_valid),
    .seq_slot_o  (seq_slot),
    .seq_last_o  (seq_last),
    .a_i_o       (a_i),
    .a_q_o       (a_q),
    .b_i_o       (b_i),
    .b_q_o       (b_q)
  );

  baseline_correlator u_core (
    .vis_clock    (vis_clock),
    .vis_reset    (vis_reset),
    .seq_valid_i  (seq_valid),
    .seq_slot_i   (seq_slot),
    .seq_last_i   (seq_last),
    .a_i_i        (a_i),
    .a_q_i        (a_q),
    .b_i_i        (b_i),
    .b_q_i        (b_q),
    .psum_valid_o (psum_valid),
    .psum_slot_o  (psum_slot),
    .psum_re_o    (psum_re),
    .psum_im_o    (psum_im)
  );

  vis_accumulator u_accum (
    .vis_clock    (vis_clock),
    .vis_reset    (vis_reset),
    .psum_valid_i (psum_valid),
    .psum_slot_i  (psum_slot),
    .psum_re_i    (psum_re),
    .psum_im_i    (psum_im),
    .vis_valid_o  (vis_valid_o),
    .vis_last_o   (vis_last_o),
    .vis_revis_o  (vis_revis_o),
    .vis_imvis_o  (vis_imvis_o)
  );

endmodule

// ==== verification/toy_correlator_tb.sv ====
`timescale 1ns/1ps
module toy_correlator_tb;
  import vis_pkg::*;

  localparam int SAMPLES = COUNT * BLOCKS;
  localparam int SPACING = 12;
  localparam int FIRST_LATENCY = 3;
  localparam int FRAMES_RUN = 6;
  // Every frame takes a little over SAMPLES strobe spacings
  localparam int CYCLE_LIMIT = FRAMES_RUN * SAMPLES * (SPACING + 1) + 200;

  // Stimulus patterns
  localparam int MODE_ONES = 0;
  localparam int MODE_ZEROS = 1;
  localparam int MODE_QUAD = 2;
  localparam int MODE_RANDOM = 3;

  logic                    vis_clock;
  logic                    vis_reset;
  logic                    sig_valid_i;
  logic [ANTENNAS-1:0]     sig_idata_i;
  logic [ANTENNAS-1:0]     sig_qdata_i;
  logic signed [ACCUM-1:0] vis_revis_o;
  logic signed [ACCUM-1:0] vis_imvis_o;
  logic                    vis_valid_o;
  logic                    vis_last_o;
  logic                    vis_start_o;
  logic                    vis_frame_o;

  int seed;
  int checks;
  int value_errors;
  int flag_errors;
  int frame_errors;
  int cycle_cnt;
  bit started;

  // Expected frame totals, built while the frame is sent
  int exp_re [TRATE];
  int exp_im [TRATE];

  toy_correlator i_dut (
    .vis_clock   (vis_clock),
    .vis_reset   (vis_reset),
    .sig_valid_i (sig_valid_i),
    .sig_idata_i (sig_idata_i),
    .sig_qdata_i (sig_qdata_i),
    .vis_revis_o (vis_revis_o),
    .vis_imvis_o (vis_imvis_o),
    .vis_valid_o (vis_valid_o),
    .vis_last_o  (vis_last_o),
    .vis_start_o (vis_start_o),
    .vis_frame_o (vis_frame_o)
  );

  initial vis_clock = 1'b0;
  always #10 vis_clock = ~vis_clock;

  always @(posedge vis_clock) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
      $display("=== FAIL ===");
      $finish;
    end
  end

  // Bit 1 stands for +1, bit 0 for -1
  function automatic int sign_of(input logic b);
    return b ? 1 : -1;
  endfunction

  // Product rule applied to every baseline of one sample
  task automatic model_sample(input logic [ANTENNAS-1:0] ib, input logic [ANTENNAS-1:0] qb);
    int ai;
    int aq;
    int bi;
    int bq;
    for (int s = 0; s < TRATE; s++) begin
      ai = sign_of(ib[A_TAPS[s]]);
      aq = sign_of(qb[A_TAPS[s]]);
      bi = sign_of(ib[B_TAPS[s]]);
      bq = sign_of(qb[B_TAPS[s]]);
      exp_re[s] += ai * bi + aq * bq;
      exp_im[s] += aq * bi - ai * bq;
    end
  endtask

  task automatic compare_vis(input logic signed [ACCUM-1:0] got,
                             input logic signed [ACCUM-1:0] expected, input string what);
    checks++;
    if (got !== expected) begin
      value_errors++;
      $display("FAILED at %0t: %s is %0d, expected %0d", $time, what, got, expected);
    end
  endtask

  task automatic compare_flag(input logic got, input logic expected, input string what);
    checks++;
    if (got !== expected) begin
      flag_errors++;
      $display("FAILED at %0t: %s is %b, expected %b", $time, what, got, expected);
    end
  endtask

  task automatic apply_reset();
    vis_reset = 1'b1;
    repeat (4) @(negedge vis_clock);
    vis_reset = 1'b0;
  endtask

  // One-cycle strobe, then the status flags it should have caused
  task automatic send_sample(input logic [ANTENNAS-1:0] ib, input logic [ANTENNAS-1:0] qb);
    @(negedge vis_clock);
    sig_valid_i = 1'b1;
    sig_idata_i = ib;
    sig_qdata_i = qb;
    @(negedge vis_clock);
    sig_valid_i = 1'b0;
    compare_flag(vis_start_o, ~started, "vis_start_o after strobe");
    compare_flag(vis_frame_o, 1'b1, "vis_frame_o after strobe");
    started = 1'b1;
  endtask

  // No output words are due while a frame is still filling
  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(negedge vis_clock);
      compare_flag(vis_valid_o, 1'b0, "vis_valid_o outside a frame");
      compare_flag(vis_start_o, 1'b0, "vis_start_o after first strobe");
      compare_flag(vis_frame_o, 1'b1, "vis_frame_o level");
    end
  endtask

  // Entered one cycle after the frame's last strobe
  task automatic collect_frame(input string name);
    int waited;
    waited = 1;
    while (vis_valid_o !== 1'b1 && waited < FIRST_LATENCY + 8) begin
      @(negedge vis_clock);
      waited++;
    end
    if (vis_valid_o !== 1'b1) begin
      frame_errors++;
      $display("Frame '%s' never came out: no vis_valid_o within %0d cycles", name, waited);
    end else begin
      checks++;
      if (waited != FIRST_LATENCY) begin
        value_errors++;
        $display("FAILED at %0t: %s first word after %0d cycles, expected %0d",
                 $time, name, waited, FIRST_LATENCY);
      end
      for (int s = 0; s < TRATE; s++) begin
        if (s > 0) begin
          @(negedge vis_clock);
          compare_flag(vis_valid_o, 1'b1, $sformatf("%s slot %0d valid", name, s));
        end
        compare_flag(vis_last_o, (s == TRATE - 1), $sformatf("%s slot %0d last", name, s));
        compare_vis(vis_revis_o, ACCUM'(exp_re[s]), $sformatf("%s slot %0d real", name, s));
        compare_vis(vis_imvis_o, ACCUM'(exp_im[s]), $sformatf("%s slot %0d imag", name, s));
      end
      // Stream stops after the tenth word
      @(negedge vis_clock);
      compare_flag(vis_valid_o, 1'b0, $sformatf("%s valid after slot 9", name));
      compare_flag(vis_last_o, 1'b0, $sformatf("%s last after slot 9", name));
    end
  endtask

  task automatic run_frame(input int mode, input string name);
    logic [ANTENNAS-1:0] ib;
    logic [ANTENNAS-1:0] qb;
    logic [31:0]         rnd;
    for (int s = 0; s < TRATE; s++) begin
      exp_re[s] = 0;
      exp_im[s] = 0;
    end
    for (int n = 0; n < SAMPLES; n++) begin
      case (mode)
        MODE_ONES: begin
          ib = '1;
          qb = '1;
        end
        MODE_ZEROS: begin
          ib = '0;
          qb = '0;
        end
        MODE_QUAD: begin
          // Antenna 1 at I=1 Q=0, the rest at I=0 Q=1
          ib = 4'b0010;
          qb = 4'b1101;
        end
        default: begin
          rnd = $random(seed);
          ib = rnd[ANTENNAS-1:0];
          qb = rnd[2*ANTENNAS-1:ANTENNAS];
        end
      endcase
      model_sample(ib, qb);
      send_sample(ib, qb);
      if (n < SAMPLES - 1) begin
        idle_cycles(SPACING - 2);
      end else begin
        collect_frame(name);
      end
    end
  endtask

  task automatic test_reset_status();
    @(negedge vis_clock);
    compare_flag(vis_valid_o, 1'b0, "vis_valid_o after reset");
    compare_flag(vis_last_o, 1'b0, "vis_last_o after reset");
    compare_flag(vis_start_o, 1'b0, "vis_start_o after reset");
    compare_flag(vis_frame_o, 1'b0, "vis_frame_o after reset");
    compare_vis(vis_revis_o, '0, "vis_revis_o after reset");
    compare_vis(vis_imvis_o, '0, "vis_imvis_o after reset");
    // First strobe of this frame raises start and frame
    run_frame(MODE_ZEROS, "reset frame");
  endtask

  task automatic test_identical();
    run_frame(MODE_ONES, "identical");
  endtask

  task automatic test_quadrature();
    run_frame(MODE_QUAD, "quadrature");
  endtask

  task automatic test_random();
    run_frame(MODE_RANDOM, "random");
  endtask

  task automatic test_back_to_back();
    run_frame(MODE_RANDOM, "back-to-back 1");
    run_frame(MODE_RANDOM, "back-to-back 2");
  endtask

  initial begin
    seed = 54;
    checks = 0;
    value_errors = 0;
    flag_errors = 0;
    frame_errors = 0;
    cycle_cnt = 0;
    started = 1'b0;
    vis_reset = 1'b1;
    sig_valid_i = 1'b0;
    sig_idata_i = '0;
    sig_qdata_i = '0;

    apply_reset();
    test_reset_status();
    test_identical();
    test_quadrature();
    test_random();
    test_back_to_back();
    idle_cycles(4);

    $display("Summary: %0d checks, %0d value errors, %0d flag errors, %0d missing frames",
             checks, value_errors, flag_errors, frame_errors);
    if (value_errors + flag_errors + frame_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== files.f ====
source/vis_pkg.sv
source/sample_sequencer.sv
source/baseline_correlator.sv
source/vis_accumulator.sv
source/toy_correlator.sv
verification/toy_correlator_tb.sv

// ==== Bender.yml ====
package:
  name: toy_correlator

sources:
  - source/vis_pkg.sv
  - source/sample_sequencer.sv
  - source/baseline_correlator.sv
  - source/vis_accumulator.sv
  - source/toy_correlator.sv
  - target: test
    files:
      - verification/toy_correlator_tb.sv
